// File: cpu_ctl_pkg.sv
// Control unit package: ROM sizes, sequencing codes, area offsets, ab codes, control word union
`default_nettype none

package cpu_ctl_pkg;

    // Microcode ROM geometry
    localparam int rom_depth = 512;                 // Words in ROM
    localparam int rom_aw    = 9;                   // Microcode address width
    localparam int ctl_w     = 32;                  // Control word width

    // Sequencing field, control bits 23:22
    localparam logic [1:0] seq_fetch     = 2'b00;   // Sync, decode next opcode
    localparam logic [1:0] seq_next      = 2'b01;   // Follow next field
    localparam logic [1:0] seq_finish    = 2'b10;   // Jump to finisher
    localparam logic [1:0] seq_next_save = 2'b11;   // Follow next, load finish ptr

    // Offsets inside the upper half of the ROM
    localparam logic [1:0] area_finish = 2'b10;         // Finishers at 140/1C0
    localparam logic [6:0] area_intr   = 7'b110_0000;   // IRQ at 160, NMI at 1E0

    // Address bus codes, control bits 27:24
    localparam logic [3:0] ab_plus0     = 4'h0;     // AB + 0
    localparam logic [3:0] ab_pc        = 4'h1;     // PC
    localparam logic [3:0] ab_db_ahl_pc = 4'h2;     // {DB, AHL+REG}, store PC
    localparam logic [3:0] ab_zp_reg    = 4'h3;     // {00, DB+REG}
    localparam logic [3:0] ab_plus1_pc  = 4'h4;     // AB + 1, store PC
    localparam logic [3:0] ab_sp_pull   = 4'h5;     // {01, SP+1}
    localparam logic [3:0] ab_branch    = 4'h7;     // Relative branch
    localparam logic [3:0] ab_sp_keep   = 4'h8;     // {01, SP}, keep PC
    localparam logic [3:0] ab_sp_push   = 4'h9;     // {01, SP}, store PC+1
    localparam logic [3:0] ab_db_ahl    = 4'hA;     // {DB, AHL+REG}, keep PC
    localparam logic [3:0] ab_sp        = 4'hB;     // {01, SP}
    localparam logic [3:0] ab_plus1     = 4'hC;     // AB + 1, keep PC
    localparam logic [3:0] ab_zp_inc    = 4'hD;     // {00, DB+REG+1}, keep PC
    localparam logic [3:0] ab_ff_reg    = 4'hF;     // {FF, REG} + 1

    // One control word per cycle, low bits read two ways
    typedef union packed {
        struct packed {                             // Mid-instruction view
            logic       ld_m;                       // Load memory data
            logic [1:0] do_op;                      // Data out op
            logic       we_next;                    // Write enable for next cycle
            logic [3:0] ab;                         // Address bus code
            logic [1:0] seq;                        // Sequencing code
            logic [6:0] reg_op;                     // Register file control
            logic [4:0] fin;                        // Finish pointer
            logic [1:0] ci;                         // Carry-in select
            logic [7:0] nxt;                        // Next address, low 7 used
        } ctl_seq;
        struct packed {                             // Final-cycle view
            logic       ld_m;
            logic [1:0] do_op;
            logic       we_next;
            logic [3:0] ab;
            logic [1:0] seq;
            logic [6:0] reg_op;
            logic [1:0] shift;                      // Shifter op
            logic [2:0] adder;                      // Adder op
            logic [1:0] ci;
            logic [7:0] flags;                      // Flag update select
        } ctl_last;
    } ctl_word_u;

endpackage

`default_nettype wire

// File: microcode_rom.sv
// Microcode ROM, 512 words of 32 bits with registered output and stall enable
`timescale 1ns/100ps
`default_nettype none

module microcode_rom
    import cpu_ctl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,          // Stall when low
    input  logic [rom_aw-1:0] addr,         // Next micro address
    output ctl_word_u         data          // Current control word
);

    logic [ctl_w-1:0] mem [rom_depth];      // ROM array

    // Unlisted words stay zero, i.e. a plain fetch
    initial begin
        for (int k = 0; k < rom_depth; k++) begin
            mem[k] = '0;
        end
        $readmemh("microcode.hex", mem);    // Sparse image with @ markers
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '0;                     // Fetch, all ops idle
        end else if (rdy) begin
            data <= mem[addr];              // One word per rdy cycle
        end
    end

endmodule

`default_nettype wire

// File: irq_detect.sv
// Interrupt detector: NMI edge flag held until taken, IRQ masked by I flag
`timescale 1ns/100ps
`default_nettype none

module irq_detect
    import cpu_ctl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic nmi,               // Edge sensitive
    input  logic irq,               // Level sensitive
    input  logic i,                 // Interrupt disable flag
    input  logic sync,              // Instruction boundary
    input  logic rdy,
    output logic take_nmi,          // NMI pending
    output logic take_irq           // Unmasked IRQ
);

    logic nmi_q;                    // Previous nmi level

    always_ff @(posedge clk) begin
        if (rst) begin
            nmi_q <= 1'b0;
        end else begin
            nmi_q <= nmi;           // Sampled even while stalled
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            take_nmi <= 1'b0;
        end else if (nmi && !nmi_q) begin
            take_nmi <= 1'b1;       // Rising edge wins over clear
        end else if (sync && rdy) begin
            take_nmi <= 1'b0;       // Taken at accepted boundary
        end
    end

    // NMI against IRQ priority sits in the sequencer
    assign take_irq = irq & ~i;

endmodule

`default_nettype wire

// File: micro_sequencer.sv
// Micro sequencer: next ROM address select, finish pointer and registered write enable
`timescale 1ns/100ps
`default_nettype none

module micro_sequencer
    import cpu_ctl_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              take_nmi,
    input  logic              take_irq,
    input  logic              d,            // Decimal flag, picks ROM quarter
    input  logic [7:0]        db,           // Opcode byte at fetch
    input  ctl_word_u         ctl,          // Current control word
    output logic [rom_aw-1:0] addr,         // Next micro address
    output logic              sync,
    output logic              we
);

    logic [4:0] fin_q;                      // Saved finisher pointer
    logic [1:0] seq;
    logic       go_next;
    logic       go_finish;
    logic       go_intr;

    assign seq  = ctl.ctl_seq.seq;
    assign sync = (seq == seq_fetch);

    // Selection priority: next, finish, interrupt, fetch
    assign go_next   = (seq == seq_next) || (seq == seq_next_save);
    assign go_finish = (seq == seq_finish);
    assign go_intr   = sync && (take_nmi || take_irq);

    /*
     * Address layout
     *   fetch   0 | opcode
     *   next    1 | D | next[6:0]            100/180
     *   finish  1 | D | 10 | fin             140/1C0
     *   intr    1 | N | 1100000              160/1E0
     */
    always_comb begin
        if (go_next) begin
            addr = {1'b1, d, ctl.ctl_seq.nxt[6:0]};
        end else if (go_finish) begin
            addr = {1'b1, d, area_finish, fin_q};
        end else if (go_intr) begin
            addr = {1'b1, take_nmi, area_intr};     // NMI above IRQ
        end else begin
            addr = {1'b0, db};                      // Opcode decode
        end
    end

    // Finish field shares bits with the ALU, free when seq bit 1 set
    always_ff @(posedge clk) begin
        if (rst) begin
            fin_q <= '0;
        end else if (rdy && seq[1]) begin
            fin_q <= ctl.ctl_seq.fin;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            we <= 1'b0;
        end else if (rdy) begin
            we <= ctl.ctl_seq.we_next;      // Write happens next cycle
        end
    end

endmodule

`default_nettype wire

// File: ab_op_expand.sv
// Address bus op expander: 4-bit ab code to 12-bit ABH/ABL control, with backward branch
`timescale 1ns/100ps
`default_nettype none

module ab_op_expand
    import cpu_ctl_pkg::*;
(
    input  logic [3:0]  ab,             // Compressed code
    input  logic        abl_ci,         // ABL carry-in
    input  logic [1:0]  abl_sel,        // ABL source select
    input  logic        cond,           // Branch taken
    input  logic        db_sign,        // Offset sign, DB bit 7
    output logic [11:0] ab_op
);

    logic back;

    assign back = cond & db_sign;       // Taken backward branch

    // Field order: PC/ABH (7), ABL sel (2), ABL op (2), carry-in
    always_comb begin
        case (ab)
            ab_plus0:     ab_op = {7'b001_0110, abl_sel, 2'b11, abl_ci};
            ab_pc:        ab_op = {7'b000_1010, abl_sel, 2'b10, abl_ci};
            ab_db_ahl_pc: ab_op = {7'b111_1110, abl_sel, 2'b01, abl_ci};
            ab_zp_reg:    ab_op = {7'b111_0000, abl_sel, 2'b01, abl_ci};
            ab_plus1_pc:  ab_op = {7'b011_0110, abl_sel, 2'b11, abl_ci};
            ab_sp_pull:   ab_op = {7'b011_0001, abl_sel, 2'b00, abl_ci};
            ab_branch: begin
                if (back) begin
                    ab_op = {7'b011_0111, abl_sel, 2'b11, abl_ci};  // {AB-1, AB}+DB+1
                end else begin
                    ab_op = {7'b011_0110, abl_sel, 2'b11, abl_ci};  // AB + 1
                end
            end
            ab_sp_keep:   ab_op = {7'b000_0001, abl_sel, 2'b00, abl_ci};
            ab_sp_push:   ab_op = {7'b111_0001, abl_sel, 2'b00, abl_ci};
            ab_db_ahl:    ab_op = {7'b001_1110, abl_sel, 2'b01, abl_ci};
            ab_sp:        ab_op = {7'b010_0001, abl_sel, 2'b00, abl_ci};
            ab_plus1:     ab_op = {7'b001_0110, abl_sel, 2'b11, abl_ci};
            ab_zp_inc:    ab_op = {7'b001_0000, abl_sel, 2'b01, abl_ci};
            ab_ff_reg:    ab_op = {7'b000_0011, abl_sel, 2'b00, abl_ci};
            default:      ab_op = 12'h000;                                 // Unused codes idle
        endcase
    end

endmodule

`default_nettype wire

// File: cpu_ctl.sv
// Control unit top: ROM, interrupt detector, sequencer, ab expander and output slicing
`timescale 1ns/100ps
`default_nettype none

module cpu_ctl
    import cpu_ctl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        rdy,            // Stall when low
    input  logic        irq,
    input  logic        nmi,
    input  logic        i,              // Interrupt disable flag
    input  logic        d,              // Decimal flag
    input  logic        cond,           // Branch condition
    input  logic [7:0]  db,             // Data bus in
    output logic        sync,           // Opcode fetch cycle
    output logic        we,
    output logic        ld_m,
    output logic        b,              // Break bit for pushed status
    output logic [9:0]  flag_op,
    output logic [6:0]  alu_op,
    output logic [6:0]  reg_op,
    output logic [1:0]  do_op,
    output logic [11:0] ab_op
);

    ctl_word_u         ctl;             // Current control word
    logic [rom_aw-1:0] addr;
    logic              take_nmi;
    logic              take_irq;

    microcode_rom rom_i (
        .clk  (clk),
        .rst  (rst),
        .rdy  (rdy),
        .addr (addr),
        .data (ctl)
    );

    irq_detect irq_i (
        .clk      (clk),
        .rst      (rst),
        .nmi      (nmi),
        .irq      (irq),
        .i        (i),
        .sync     (sync),
        .rdy      (rdy),
        .take_nmi (take_nmi),
        .take_irq (take_irq)
    );

    micro_sequencer seq_i (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .take_nmi (take_nmi),
        .take_irq (take_irq),
        .d        (d),
        .db       (db),
        .ctl      (ctl),
        .addr     (addr),
        .sync     (sync),
        .we       (we)
    );

    ab_op_expand ab_i (
        .ab      (ctl.ctl_seq.ab),
        .abl_ci  (ctl.ctl_seq.ab[2]),       // Carry-in rides in the code
        .abl_sel (ctl.ctl_seq.ab[1:0]),
        .cond    (cond),
        .db_sign (db[7]),
        .ab_op   (ab_op)
    );

    assign ld_m    = ctl.ctl_seq.ld_m & rdy;            // No load during stall
    assign do_op   = ctl.ctl_seq.do_op;
    assign reg_op  = ctl.ctl_seq.reg_op;
    assign flag_op = {ctl.ctl_last.do_op, ctl.ctl_last.flags};
    assign alu_op  = {ctl.ctl_last.shift, ctl.ctl_last.adder, ctl.ctl_last.ci};
    assign b       = ctl.ctl_last.ci[0];                // ALU idle on status push

endmodule

`default_nettype wire

// File: tb_checker.sv
// Testbench checker: reference model of the control unit and per-cycle output compare
`timescale 1ns/100ps
`default_nettype none

module tb_checker
    import cpu_ctl_pkg::*;
(
    input  logic        clk, rst, rdy, irq, nmi, i, d, cond,
    input  logic [7:0]  db,
    input  logic        sync, we, ld_m, b,
    input  logic [9:0]  flag_op,
    input  logic [6:0]  alu_op,
    input  logic [6:0]  reg_op,
    input  logic [1:0]  do_op,
    input  logic [11:0] ab_op,
    output int          err_count,
    output int          check_count
);

    logic [ctl_w-1:0]  rom_img [rom_depth];  // Own copy of the microcode
    logic [6:0]        ab_hi [16];           // PC/ABH control per ab code
    logic [1:0]        ab_lo [16];           // ABL op per ab code
    ctl_word_u         cw;                   // Predicted control word
    logic [4:0]        fin_m;
    logic              we_m;
    logic              nmi_q_m;
    logic              nmi_m;                // Pending NMI
    logic [rom_aw-1:0] addr_m;

    initial begin
        for (int k = 0; k < rom_depth; k++) begin
            rom_img[k] = '0;
        end
        $readmemh("microcode.hex", rom_img);
        err_count   = 0;
        check_count = 0;
        ab_hi = '{7'h16, 7'h0A, 7'h7E, 7'h70, 7'h36, 7'h31, 7'h00, 7'h36,
                  7'h01, 7'h71, 7'h1E, 7'h21, 7'h16, 7'h10, 7'h00, 7'h03};
        ab_lo = '{2'd3, 2'd2, 2'd1, 2'd1, 2'd3, 2'd0, 2'd0, 2'd3,
                  2'd0, 2'd0, 2'd1, 2'd0, 2'd3, 2'd1, 2'd0, 2'd0};
    end

    function automatic logic [11:0] ab_expect(input logic [3:0] code, input logic back);
        logic [6:0] hi;
        hi = ab_hi[code];
        if (code == ab_branch && back) begin
            hi = 7'h37;                      // Backward form decrements ABH
        end
        if (code == 4'h6 || code == 4'hE) begin
            return 12'h000;                  // Illegal codes idle
        end
        return {hi, code[1:0], ab_lo[code], code[2]};
    endfunction

    // Next, finish, interrupt, fetch in that order
    always_comb begin
        if (cw.ctl_seq.seq[0]) begin
            addr_m = {1'b1, d, cw.ctl_seq.nxt[6:0]};
        end else if (cw.ctl_seq.seq == seq_finish) begin
            addr_m = {1'b1, d, area_finish, fin_m};
        end else if (nmi_m || (irq && !i)) begin
            addr_m = {1'b1, nmi_m, area_intr};
        end else begin
            addr_m = {1'b0, db};
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cw      <= '0;
            fin_m   <= '0;
            we_m    <= 1'b0;
            nmi_q_m <= 1'b0;
            nmi_m   <= 1'b0;
        end else begin
            nmi_q_m <= nmi;
            if (nmi && !nmi_q_m) begin
                nmi_m <= 1'b1;
            end else if (cw.ctl_seq.seq == seq_fetch && rdy) begin
                nmi_m <= 1'b0;
            end
            if (rdy) begin
                cw   <= rom_img[addr_m];
                we_m <= cw.ctl_seq.we_next;
                if (cw.ctl_seq.seq[1]) begin
                    fin_m <= cw.ctl_seq.fin;
                end
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Mid-cycle, inputs settled since 1 ns after the edge
    always @(negedge clk) begin
        if (!rst) begin
            compare("sync", sync, cw.ctl_seq.seq == seq_fetch);
            compare("we", we, we_m);
            compare("ld_m", ld_m, cw.ctl_seq.ld_m & rdy);
            compare("b", b, cw[8]);
            compare("flag_op", flag_op, {cw[30:29], cw[7:0]});
            compare("alu_op", alu_op, cw[14:8]);
            compare("reg_op", reg_op, cw[21:15]);
            compare("do_op", do_op, cw[30:29]);
            compare("ab_op", ab_op, ab_expect(cw[27:24], cond & db[7]));
        end
    end

endmodule

`default_nettype wire

// File: tb_cpu_ctl.sv
// Testbench top: clock, reset, stimulus table with LCG filler, watchdog and summary
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_ctl;

    typedef struct packed {
        logic [7:0] test;
        logic [7:0] db;
        logic [6:0] ctl;                     // rdy irq nmi i d cond rnd
    } row_t;

    logic        clk, rst, rdy, irq, nmi, i, d, cond;
    logic [7:0]  db;
    logic        sync, we, ld_m, b;
    logic [9:0]  flag_op;
    logic [6:0]  alu_op;
    logic [6:0]  reg_op;
    logic [1:0]  do_op;
    logic [11:0] ab_op;
    int          err_count;
    int          check_count;
    row_t        rows[$];
    logic [31:0] lcg_state = 32'd85;

    cpu_ctl cpu_ctl_i (.clk(clk), .rst(rst), .rdy(rdy), .irq(irq), .nmi(nmi), .i(i), .d(d),
        .cond(cond), .db(db), .sync(sync), .we(we), .ld_m(ld_m), .b(b), .flag_op(flag_op),
        .alu_op(alu_op), .reg_op(reg_op), .do_op(do_op), .ab_op(ab_op));

    tb_checker chk_i (.clk(clk), .rst(rst), .rdy(rdy), .irq(irq), .nmi(nmi), .i(i), .d(d),
        .cond(cond), .db(db), .sync(sync), .we(we), .ld_m(ld_m), .b(b), .flag_op(flag_op),
        .alu_op(alu_op), .reg_op(reg_op), .do_op(do_op), .ab_op(ab_op),
        .err_count(err_count), .check_count(check_count));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;               // 4 ns period
    end

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic add_row(input int test, input logic [7:0] db_v, input logic [6:0] ctl_v);
        rows.push_back('{test[7:0], db_v, ctl_v});
    endtask

    initial begin
        int cur_test;
        int err_mark;
        logic [7:0] rnd;
        rst  = 1'b1;
        rdy  = 1'b0;
        irq  = 1'b0;
        nmi  = 1'b0;
        i    = 1'b0;
        d    = 1'b0;
        cond = 1'b0;
        db   = 8'h00;
        // Fetch decode
        add_row(1, 8'h01, 7'b1000000);
        repeat (2) add_row(1, 8'h00, 7'b1000000);
        // Sequence with save and finish, D clear then set
        add_row(2, 8'h10, 7'b1000000);
        repeat (5) add_row(2, 8'h00, 7'b1000000);
        add_row(2, 8'h10, 7'b1000100);
        repeat (5) add_row(2, 8'h00, 7'b1000100);
        // IRQ taken, IRQ masked, NMI over held IRQ
        add_row(3, 8'h00, 7'b1100000);
        repeat (3) add_row(3, 8'h00, 7'b1000000);
        repeat (2) add_row(3, 8'h00, 7'b1101000);
        repeat (6) add_row(3, 8'h00, 7'b1110000);
        repeat (3) add_row(3, 8'h00, 7'b1000000);
        // Stalls on the save, load and finish words
        add_row(4, 8'h10, 7'b1000000);
        repeat (2) add_row(4, 8'h00, 7'b0000000);
        add_row(4, 8'h00, 7'b1000000);
        add_row(4, 8'h00, 7'b0000000);
        add_row(4, 8'h00, 7'b1000000);
        add_row(4, 8'h00, 7'b0000000);
        repeat (3) add_row(4, 8'h00, 7'b1000000);
        // Every ab code with a taken backward offset
        for (int n = 0; n < 16; n++) begin
            add_row(5, 8'h30 + n[7:0], 7'b1000000);
            add_row(5, 8'h80, 7'b1000010);
        end
        add_row(5, 8'h20, 7'b1000000);
        add_row(5, 8'h00, 7'b1000010);       // Taken, forward offset
        add_row(5, 8'h37, 7'b1000000);
        add_row(5, 8'h80, 7'b1000000);       // Not taken, negative offset
        // Random db and cond
        repeat (20) add_row(6, 8'h00, 7'b1000001);

        repeat (4) @(posedge clk);
        cur_test = rows[0].test;
        err_mark = 0;
        foreach (rows[k]) begin
            if (k > 0) @(posedge clk);
            #1;
            rst = 1'b0;
            if (rows[k].test != cur_test) begin
                $display("test %0d done, %0d errors", cur_test, err_count - err_mark);
                cur_test = rows[k].test;
                err_mark = err_count;
            end
            {rdy, irq, nmi, i, d} = rows[k].ctl[6:2];
            db   = rows[k].db;
            cond = rows[k].ctl[1];
            if (rows[k].ctl[0]) begin
                rnd  = lcg_byte();
                db   = rnd;
                cond = lcg_byte() > 8'h7F;
            end
        end
        @(posedge clk);
        @(negedge clk);
        #1;
        $display("test %0d done, %0d errors", cur_test, err_count - err_mark);
        $display("%0d rows, %0d checks, %0d errors", rows.size(), check_count, err_count);
        if (err_count == 0 && check_count > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run length follows the table size
    initial begin
        int limit;
        #1;
        limit = (rows.size() + 4 + 20) * 4;
        #(limit);
        $display("Timeout: stimulus did not complete within %0d ns", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
cpu_ctl_pkg.sv
microcode_rom.sv
irq_detect.sv
micro_sequencer.sv
ab_op_expand.sv
cpu_ctl.sv
tb_checker.sv
tb_cpu_ctl.sv

// File: Bender.yml
package:
  name: cpu_ctl

sources:
  - cpu_ctl_pkg.sv
  - microcode_rom.sv
  - irq_detect.sv
  - micro_sequencer.sv
  - ab_op_expand.sv
  - cpu_ctl.sv
  - target: test
    files:
      - tb_checker.sv
      - tb_cpu_ctl.sv

// File: microcode.hex
// One 32-bit control word per line in hex, @ lines set the word address
// Bits 31 ld_m, 30:29 do_op, 28 we_next, 27:24 ab, 23:22 seq, 21:15 reg_op, 14:0 alu/fin/next/flags
@001
8108A95C // Single-cycle op with ALU and flag fields
@010
19C00C05 // Push with write, save finisher 3, next 05
@020
0712B456 // Branch code in a fetch word
@030
00123400
01123401
02123402
03123403
04123404
05123405
06123406
07123407
08123408
09123409
0A12340A
0B12340B
0C12340C
0D12340D
0E12340E
0F12340F
@101
0B3F0101 // IRQ tail, back to fetch
0A200202 // NMI tail
@105
8A400006 // Load, next 06, D clear
0B800000 // Jump to finisher
@143
6C2AB7E5 // Finisher 3, D clear
@160
19400001 // IRQ entry, push
@185
8F400006 // Load, next 06, D set
07800000 // Jump to finisher
@1C3
4D1556AA // Finisher 3, D set
@1E0
18400002 // NMI entry, push
